//--- logic/cpu_consts.svh
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

`define WORD_WIDTH 16
`define REG_COUNT  8
`define PROG_DEPTH 256
`define DATA_DEPTH 256

// Stack grows down from here
`define STACK_TOP  255

`endif

//--- logic/cpuPkg.sv
package cpuPkg;

   typedef enum logic [3:0] {
      ADD  = 4'h0,
      SUB  = 4'h1,
      AND  = 4'h2,
      OR   = 4'h3,
      XOR  = 4'h4,
      SHL  = 4'h5,
      SHR  = 4'h6,
      LDI  = 4'h7,
      LD   = 4'h8,
      ST   = 4'h9,
      PUSH = 4'hA,
      POP  = 4'hB,
      BR   = 4'hC,
      OUT  = 4'hD,
      HALT = 4'hE,
      NOP  = 4'hF
   } opcodeT;

   typedef enum logic [1:0] {
      ALWAYS   = 2'd0,
      ZERO     = 2'd1,
      NOTZERO  = 2'd2,
      NEGATIVE = 2'd3
   } condT;

   typedef struct packed {
      opcodeT     opcode;
      logic [2:0] rd;
      logic [2:0] ra;
      logic [2:0] rb;
      logic [2:0] spare;
   } regFormT;

   typedef struct packed {
      opcodeT     opcode;
      logic [2:0] rd;   // BR keeps its condition here
      logic [8:0] imm;  // BR target in the low byte
   } immFormT;

   typedef union packed {
      regFormT regForm;
      immFormT immForm;
   } instrWord;

endpackage

//--- logic/decodeStage.sv
`include "cpu_consts.svh"

module decodeStage import cpuPkg::*; (
   input  logic                   CLK,
   input  logic                   reset,
   input  logic                   run,
   input  logic                   progWrite,
   input  logic [7:0]             progAddr,
   input  logic [`WORD_WIDTH-1:0] progData,
   input  logic                   pcLoad,
   input  logic [7:0]             pcTarget,
   input  logic                   halted,
   output opcodeT                 opcode,
   output logic [2:0]             rd,
   output logic [2:0]             ra,
   output logic [2:0]             rb,
   output logic [8:0]             imm,
   output condT                   cond,
   output logic                   regWrite,
   output logic                   memRead,
   output logic                   memWrite,
   output logic                   spInc,
   output logic                   spDec,
   output logic                   isBranch,
   output logic                   isOut,
   output logic                   isHalt
);

   logic [`WORD_WIDTH-1:0] progMem [`PROG_DEPTH];
   logic [7:0]             pc;
   instrWord               word;
   logic                   active;

   always_ff @(posedge CLK) begin
      if (progWrite && !run) begin
         progMem[progAddr] <= progData;
      end
   end

   always_ff @(posedge CLK) begin
      if (reset || !run) begin
         pc <= '0;                 // Fetch restarts at 0 when run rises
      end else if (pcLoad) begin
         pc <= pcTarget;
      end else if (!halted) begin
         pc <= pc + 8'd1;
      end
   end

   assign word   = progMem[pc];
   assign active = run && !halted;

   always_comb begin
      opcode   = NOP;
      rd       = '0;
      ra       = '0;
      rb       = '0;
      imm      = '0;
      cond     = ALWAYS;
      regWrite = 1'b0;
      memRead  = 1'b0;
      memWrite = 1'b0;
      spInc    = 1'b0;
      spDec    = 1'b0;
      isBranch = 1'b0;
      isOut    = 1'b0;
      isHalt   = 1'b0;
      if (active) begin
         opcode = word.regForm.opcode;
         case (word.regForm.opcode)
            ADD, SUB, AND, OR, XOR, SHL, SHR: begin
               rd       = word.regForm.rd;
               ra       = word.regForm.ra;
               rb       = word.regForm.rb;
               regWrite = 1'b1;
            end
            LDI: begin
               rd       = word.immForm.rd;
               imm      = word.immForm.imm;
               regWrite = 1'b1;
            end
            LD: begin
               rd       = word.regForm.rd;
               ra       = word.regForm.ra;   // Address register
               regWrite = 1'b1;
               memRead  = 1'b1;
            end
            ST: begin
               ra       = word.regForm.ra;
               rb       = word.regForm.rb;   // Data register
               memWrite = 1'b1;
            end
            PUSH: begin
               ra       = word.regForm.ra;
               memWrite = 1'b1;
               spDec    = 1'b1;
            end
            POP: begin
               rd       = word.regForm.rd;
               regWrite = 1'b1;
               memRead  = 1'b1;
               spInc    = 1'b1;
            end
            BR: begin
               cond     = condT'(word.immForm.rd[1:0]);
               imm      = word.immForm.imm;
               isBranch = 1'b1;
            end
            OUT: begin
               ra       = word.regForm.ra;
               isOut    = 1'b1;
            end
            HALT: isHalt = 1'b1;
            default: ;
         endcase
      end
   end

endmodule

//--- logic/decodeRegister.sv
module decodeRegister import cpuPkg::*; (
   input  logic       CLK,
   input  logic       reset,
   input  logic       flush,
   input  opcodeT     opcode,
   input  logic [2:0] rd,
   input  logic [2:0] ra,
   input  logic [2:0] rb,
   input  logic [8:0] imm,
   input  condT       cond,
   input  logic       regWrite,
   input  logic       memRead,
   input  logic       memWrite,
   input  logic       spInc,
   input  logic       spDec,
   input  logic       isBranch,
   input  logic       isOut,
   input  logic       isHalt,
   output opcodeT     opcodeQ,
   output logic [2:0] rdQ,
   output logic [2:0] raQ,
   output logic [2:0] rbQ,
   output logic [8:0] immQ,
   output condT       condQ,
   output logic       regWriteQ,
   output logic       memReadQ,
   output logic       memWriteQ,
   output logic       spIncQ,
   output logic       spDecQ,
   output logic       isBranchQ,
   output logic       isOutQ,
   output logic       isHaltQ
);

   always_ff @(posedge CLK) begin
      if (reset || flush) begin
         opcodeQ   <= NOP;          // Bubble
         regWriteQ <= 1'b0;
         memReadQ  <= 1'b0;
         memWriteQ <= 1'b0;
         spIncQ    <= 1'b0;
         spDecQ    <= 1'b0;
         isBranchQ <= 1'b0;
         isOutQ    <= 1'b0;
         isHaltQ   <= 1'b0;
      end else begin
         opcodeQ   <= opcode;
         regWriteQ <= regWrite;
         memReadQ  <= memRead;
         memWriteQ <= memWrite;
         spIncQ    <= spInc;
         spDecQ    <= spDec;
         isBranchQ <= isBranch;
         isOutQ    <= isOut;
         isHaltQ   <= isHalt;
      end
   end

   // Operand fields follow the decoder
   always_ff @(posedge CLK) begin
      rdQ   <= rd;
      raQ   <= ra;
      rbQ   <= rb;
      immQ  <= imm;
      condQ <= cond;
   end

endmodule

//--- logic/executeStage.sv
`include "cpu_consts.svh"

module executeStage import cpuPkg::*; (
   input  logic                   CLK,
   input  logic                   reset,
   input  opcodeT                 opcodeQ,
   input  logic [2:0]             rdQ,
   input  logic [2:0]             raQ,
   input  logic [2:0]             rbQ,
   input  logic [8:0]             immQ,
   input  condT                   condQ,
   input  logic                   regWriteQ,
   input  logic                   memReadQ,
   input  logic                   memWriteQ,
   input  logic                   spIncQ,
   input  logic                   spDecQ,
   input  logic                   isBranchQ,
   input  logic                   isOutQ,
   input  logic                   isHaltQ,
   input  logic                   resWriteEnable,
   input  logic [2:0]             resWriteAddr,
   input  logic [`WORD_WIDTH-1:0] resWriteData,
   output logic                   pcLoad,
   output logic [7:0]             pcTarget,
   output logic                   flush,
   output logic                   halted,
   output logic [7:0]             memAddr,
   output logic [`WORD_WIDTH-1:0] storeData,
   output logic [`WORD_WIDTH-1:0] aluResult,
   output logic [2:0]             resRd,
   output logic                   resRegWrite,
   output logic                   resMemRead,
   output logic                   resMemWrite,
   output logic                   resOut
);

   logic [`WORD_WIDTH-1:0] regFile [`REG_COUNT];
   logic [`WORD_WIDTH-1:0] aVal;
   logic [`WORD_WIDTH-1:0] bVal;
   logic [`WORD_WIDTH-1:0] aluOut;
   logic [`WORD_WIDTH-1:0] storeNext;
   logic [7:0]             sp;
   logic [7:0]             spNext;
   logic [7:0]             addrNext;
   logic                   zeroFlag;
   logic                   negFlag;
   logic                   setsFlags;
   logic                   condMet;

   always_ff @(posedge CLK) begin
      if (reset) begin
         for (int i = 0; i < `REG_COUNT; i++) begin
            regFile[i] <= '0;
         end
      end else if (resWriteEnable) begin
         regFile[resWriteAddr] <= resWriteData;
      end
   end

   // Result stage write bypasses the register file
   assign aVal = (resWriteEnable && resWriteAddr == raQ) ? resWriteData : regFile[raQ];
   assign bVal = (resWriteEnable && resWriteAddr == rbQ) ? resWriteData : regFile[rbQ];

   always_comb begin
      setsFlags = 1'b1;
      case (opcodeQ)
         ADD: aluOut = aVal + bVal;
         SUB: aluOut = aVal - bVal;
         AND: aluOut = aVal & bVal;
         OR:  aluOut = aVal | bVal;
         XOR: aluOut = aVal ^ bVal;
         SHL: aluOut = aVal << bVal[3:0];
         SHR: aluOut = aVal >> bVal[3:0];
         LDI: aluOut = {{(`WORD_WIDTH - 9){immQ[8]}}, immQ};
         default: begin
            aluOut    = aVal;      // OUT value
            setsFlags = 1'b0;
         end
      endcase
   end

   // PUSH predecrements, POP postincrements
   assign spNext    = spDecQ ? sp - 8'd1 : (spIncQ ? sp + 8'd1 : sp);
   assign addrNext  = spDecQ ? spNext : (spIncQ ? sp : aVal[7:0]);
   assign storeNext = spDecQ ? aVal : bVal;

   always_comb begin
      case (condQ)
         ALWAYS:   condMet = 1'b1;
         ZERO:     condMet = zeroFlag;
         NOTZERO:  condMet = !zeroFlag;
         NEGATIVE: condMet = negFlag;
         default:  condMet = 1'b0;
      endcase
   end

   assign pcLoad   = isBranchQ && condMet;
   assign pcTarget = immQ[7:0];
   assign flush    = pcLoad || isHaltQ;    // Drop the one younger instruction

   always_ff @(posedge CLK) begin
      if (reset) begin
         zeroFlag <= 1'b0;
         negFlag  <= 1'b0;
         sp       <= 8'(`STACK_TOP);
         halted   <= 1'b0;
      end else begin
         if (setsFlags) begin
            zeroFlag <= (aluOut == '0);
            negFlag  <= aluOut[`WORD_WIDTH-1];
         end
         sp <= spNext;
         if (isHaltQ) begin
            halted <= 1'b1;                  // Held until reset
         end
      end
   end

   always_ff @(posedge CLK) begin
      if (reset) begin
         resRegWrite <= 1'b0;
         resMemRead  <= 1'b0;
         resMemWrite <= 1'b0;
         resOut      <= 1'b0;
      end else begin
         resRegWrite <= regWriteQ;
         resMemRead  <= memReadQ;
         resMemWrite <= memWriteQ;
         resOut      <= isOutQ;
      end
   end

   always_ff @(posedge CLK) begin
      memAddr   <= addrNext;
      storeData <= storeNext;
      aluResult <= aluOut;
      resRd     <= rdQ;
   end

endmodule

//--- logic/resultStage.sv
`include "cpu_consts.svh"

module resultStage (
   input  logic                   CLK,
   input  logic                   reset,
   input  logic [7:0]             memAddr,
   input  logic [`WORD_WIDTH-1:0] storeData,
   input  logic [`WORD_WIDTH-1:0] aluResult,
   input  logic [2:0]             resRd,
   input  logic                   resRegWrite,
   input  logic                   resMemRead,
   input  logic                   resMemWrite,
   input  logic                   resOut,
   output logic                   resWriteEnable,
   output logic [2:0]             resWriteAddr,
   output logic [`WORD_WIDTH-1:0] resWriteData,
   output logic                   outValid,
   output logic [`WORD_WIDTH-1:0] outData
);

   logic [`WORD_WIDTH-1:0] dataMem [`DATA_DEPTH];
   logic [`WORD_WIDTH-1:0] loadData;

   assign loadData = dataMem[memAddr];     // Asynchronous read

   always_ff @(posedge CLK) begin
      if (resMemWrite) begin
         dataMem[memAddr] <= storeData;
      end
   end

   assign resWriteEnable = resRegWrite;
   assign resWriteAddr   = resRd;
   assign resWriteData   = resMemRead ? loadData : aluResult;

   always_ff @(posedge CLK) begin
      if (reset) begin
         outValid <= 1'b0;
      end else begin
         outValid <= resOut;
      end
   end

   always_ff @(posedge CLK) begin
      if (resOut) begin
         outData <= aluResult;             // Holds last OUT value
      end
   end

endmodule

//--- logic/cpuCore.sv
`include "cpu_consts.svh"

module cpuCore import cpuPkg::*; (
   input  logic                   CLK,
   input  logic                   reset,
   input  logic                   run,
   input  logic                   progWrite,
   input  logic [7:0]             progAddr,
   input  logic [`WORD_WIDTH-1:0] progData,
   output logic                   outValid,
   output logic [`WORD_WIDTH-1:0] outData,
   output logic                   halted
);

   // Decode fields
   opcodeT     opcode;
   logic [2:0] rd, ra, rb;
   logic [8:0] imm;
   condT       cond;
   logic       regWrite, memRead, memWrite, spInc, spDec, isBranch, isOut, isHalt;

   // Decode register outputs
   opcodeT     opcodeQ;
   logic [2:0] rdQ, raQ, rbQ;
   logic [8:0] immQ;
   condT       condQ;
   logic       regWriteQ, memReadQ, memWriteQ, spIncQ, spDecQ;
   logic       isBranchQ, isOutQ, isHaltQ;

   // Execute to decode
   logic       pcLoad;
   logic [7:0] pcTarget;
   logic       flush;

   // Execute to result
   logic [7:0]             memAddr;
   logic [`WORD_WIDTH-1:0] storeData;
   logic [`WORD_WIDTH-1:0] aluResult;
   logic [2:0]             resRd;
   logic                   resRegWrite, resMemRead, resMemWrite, resOut;

   // Write-back path
   logic                   resWriteEnable;
   logic [2:0]             resWriteAddr;
   logic [`WORD_WIDTH-1:0] resWriteData;

   decodeStage decodeStage_i (.*);

   decodeRegister decodeRegister_i (.*);

   executeStage executeStage_i (.*);

   resultStage resultStage_i (.*);

endmodule

//--- testbench/cpuTasks.svh
function automatic logic [15:0] signExtend(input logic [8:0] value);
   return {{7{value[8]}}, value};
endfunction

function automatic logic [15:0] regInstr(input opcodeT op, input logic [2:0] rd,
                                         input logic [2:0] ra, input logic [2:0] rb);
   instrWord w;
   w.regForm.opcode = op;
   w.regForm.rd     = rd;
   w.regForm.ra     = ra;
   w.regForm.rb     = rb;
   w.regForm.spare  = 3'd0;
   return w;
endfunction

function automatic logic [15:0] immInstr(input opcodeT op, input logic [2:0] rd,
                                         input logic [8:0] imm);
   instrWord w;
   w.immForm.opcode = op;
   w.immForm.rd     = rd;
   w.immForm.imm    = imm;
   return w;
endfunction

function automatic logic [15:0] brInstr(input condT c, input logic [7:0] target);
   return immInstr(BR, {1'b0, c}, {1'b0, target});
endfunction

// Expected ALU result with 16-bit wrap and shifts by the low four bits of b
function automatic logic [15:0] aluModel(input opcodeT op, input logic [15:0] a,
                                         input logic [15:0] b);
   case (op)
      ADD:     return a + b;
      SUB:     return a - b;
      AND:     return a & b;
      OR:      return a | b;
      XOR:     return a ^ b;
      SHL:     return a << b[3:0];
      SHR:     return a >> b[3:0];
      default: return a;
   endcase
endfunction

task automatic checkValue(input logic [15:0] actual, input logic [15:0] expectValue,
                          input string msg);
   if (actual !== expectValue) begin
      $display("mismatch at time %0t: %s: got %h, expected %h", $time, msg, actual,
               expectValue);
      mismatchCount++;
   end
endtask

task automatic resetDut();
   @(posedge CLK);
   #1;
   reset     = 1'b1;
   run       = 1'b0;
   progWrite = 1'b0;
   repeat (16) @(posedge CLK);
   #1;
   reset = 1'b0;
endtask

task automatic loadProgram();
   foreach (prog[i]) begin
      @(posedge CLK);
      #1;
      progWrite = 1'b1;
      progAddr  = 8'(i);
      progData  = prog[i];
   end
   @(posedge CLK);
   #1;
   progWrite = 1'b0;
endtask

task automatic runUntilHalt(input string name);
   int waitCycles;
   int limit;
   observed.delete();
   limit      = prog.size() * 4;
   waitCycles = 0;
   @(posedge CLK);
   #1;
   run = 1'b1;
   while (!halted && waitCycles < limit) begin
      @(posedge CLK);
      #1;
      if (outValid) observed.push_back(outData);
      waitCycles++;
   end
   if (!halted) begin
      $display("%s: program did not halt within %0d cycles", name, limit);
      otherCount++;
   end
   repeat (8) begin                        // Nothing may leave after the halt
      @(posedge CLK);
      #1;
      if (outValid) observed.push_back(outData);
   end
   if (!halted) begin
      $display("%s: halted did not stay high after the program stopped", name);
      otherCount++;
   end
   run = 1'b0;
endtask

task automatic compareOutputs(input string name);
   if (observed.size() != expected.size()) begin
      $display("%s: wrong number of outputs, expected %0d but got %0d",
               name, expected.size(), observed.size());
      otherCount++;
   end
   for (int i = 0; i < observed.size() && i < expected.size(); i++) begin
      checkValue(observed[i], expected[i], $sformatf("%s output %0d", name, i));
   end
endtask

task automatic runProgram(input string name);
   cycleLimit += prog.size() * 4 + 50;
   resetDut();
   loadProgram();
   runUntilHalt(name);
   compareOutputs(name);
endtask

//--- testbench/cpuCore_tb.sv
`include "cpu_consts.svh"

module cpuCore_tb import cpuPkg::*; ();

   logic                   CLK;
   logic                   reset;
   logic                   run;
   logic                   progWrite;
   logic [7:0]             progAddr;
   logic [`WORD_WIDTH-1:0] progData;
   logic                   outValid;
   logic [`WORD_WIDTH-1:0] outData;
   logic                   halted;

   logic [15:0] prog [$];
   logic [15:0] expected [$];
   logic [15:0] observed [$];
   integer      seed = 32'h3dfd7542;
   int          mismatchCount = 0;
   int          otherCount = 0;
   int          cycleCount = 0;
   int          cycleLimit = 16;           // Base reset allowance

   cpuCore cpuCore_i (.*);

   `include "cpuTasks.svh"

   initial begin
      CLK = 1'b0;
      forever #4 CLK = ~CLK;
   end

   initial begin
      while (cycleCount <= cycleLimit) begin
         @(posedge CLK);
         cycleCount++;
      end
      $display("timeout: the run went past its limit of %0d cycles", cycleLimit);
      $display("SIMULATION FAILED");
      $finish;
   end

   task automatic aluTest();
      opcodeT      ops [7] = '{ADD, SUB, AND, OR, XOR, SHL, SHR};
      logic [8:0]  immA;
      logic [8:0]  immB;
      logic [15:0] a;
      logic [15:0] b;
      logic [15:0] last;
      prog.delete();
      expected.delete();
      immA = 9'($random(seed));
      immB = 9'($random(seed));
      a    = signExtend(immA);
      b    = signExtend(immB);
      prog.push_back(immInstr(LDI, 3'd1, immA));
      prog.push_back(immInstr(LDI, 3'd2, immB));
      foreach (ops[k]) begin
         prog.push_back(regInstr(ops[k], 3'd3, 3'd1, 3'd2));
         prog.push_back(regInstr(OUT, 3'd0, 3'd3, 3'd0));
         expected.push_back(aluModel(ops[k], a, b));
      end
      last = aluModel(SHR, a, b);
      prog.push_back(regInstr(ADD, 3'd4, 3'd3, 3'd1));   // Chain through forwarding
      prog.push_back(regInstr(XOR, 3'd5, 3'd4, 3'd2));
      prog.push_back(regInstr(OUT, 3'd0, 3'd5, 3'd0));
      expected.push_back(aluModel(XOR, aluModel(ADD, last, a), b));
      prog.push_back(regInstr(HALT, 3'd0, 3'd0, 3'd0));
      runProgram("alu");
   endtask

   task automatic memoryTest();
      logic [7:0] addrs [3] = '{8'd17, 8'd100, 8'd200};
      logic [8:0] vals [3];
      prog.delete();
      expected.delete();
      foreach (addrs[k]) begin
         vals[k] = 9'($random(seed));
         prog.push_back(immInstr(LDI, 3'd1, {1'b0, addrs[k]}));
         prog.push_back(immInstr(LDI, 3'd2, vals[k]));
         prog.push_back(regInstr(ST, 3'd0, 3'd1, 3'd2));
      end
      for (int k = 2; k >= 0; k--) begin
         prog.push_back(immInstr(LDI, 3'd1, {1'b0, addrs[k]}));
         prog.push_back(regInstr(LD, 3'd3, 3'd1, 3'd0));
         prog.push_back(regInstr(OUT, 3'd0, 3'd3, 3'd0));
         expected.push_back(signExtend(vals[k]));
      end
      prog.push_back(regInstr(HALT, 3'd0, 3'd0, 3'd0));
      runProgram("memory");
   endtask

   task automatic stackTest();
      logic [8:0] vals [3];
      prog.delete();
      expected.delete();
      foreach (vals[k]) begin
         vals[k] = 9'($random(seed));
         prog.push_back(immInstr(LDI, 3'(k + 1), vals[k]));
      end
      for (int k = 0; k < 3; k++) prog.push_back(regInstr(PUSH, 3'd0, 3'(k + 1), 3'd0));
      for (int k = 0; k < 3; k++) prog.push_back(regInstr(POP, 3'(k + 4), 3'd0, 3'd0));
      for (int k = 0; k < 3; k++) begin
         prog.push_back(regInstr(OUT, 3'd0, 3'(k + 4), 3'd0));
         expected.push_back(signExtend(vals[2 - k]));   // Last pushed comes out first
      end
      prog.push_back(regInstr(HALT, 3'd0, 3'd0, 3'd0));
      runProgram("stack");
   endtask

   // Flag op into r4, branch over the next word, then an OUT
   task automatic addBranchCase(input opcodeT op, input logic [2:0] ra, input logic [2:0] rb,
                                input logic [15:0] a, input logic [15:0] b, input condT c);
      logic [15:0] res;
      logic [7:0]  target;
      logic        taken;
      res = aluModel(op, a, b);
      case (c)
         ALWAYS:  taken = 1'b1;
         ZERO:    taken = (res == 16'd0);
         NOTZERO: taken = (res != 16'd0);
         default: taken = res[15];
      endcase
      prog.push_back(regInstr(op, 3'd4, ra, rb));
      target = 8'(prog.size() + 2);
      prog.push_back(brInstr(c, target));
      if (taken) begin
         prog.push_back(regInstr(OUT, 3'd0, 3'd7, 3'd0));   // Must be skipped
      end else begin
         prog.push_back(regInstr(OUT, 3'd0, 3'd4, 3'd0));
         expected.push_back(res);
      end
   endtask

   task automatic branchTest();
      logic [15:0] zero;
      logic [15:0] neg;
      logic [15:0] pos;
      prog.delete();
      expected.delete();
      zero = signExtend(9'd0);
      neg  = signExtend(-9'sd5);
      pos  = signExtend(9'd3);
      prog.push_back(immInstr(LDI, 3'd1, 9'd0));
      prog.push_back(immInstr(LDI, 3'd2, -9'sd5));
      prog.push_back(immInstr(LDI, 3'd3, 9'd3));
      prog.push_back(immInstr(LDI, 3'd7, 9'd77));
      addBranchCase(ADD, 3'd1, 3'd1, zero, zero, ALWAYS);
      addBranchCase(ADD, 3'd1, 3'd1, zero, zero, ZERO);
      addBranchCase(ADD, 3'd3, 3'd1, pos, zero, ZERO);
      addBranchCase(OR,  3'd3, 3'd3, pos, pos, NOTZERO);
      addBranchCase(AND, 3'd1, 3'd3, zero, pos, NOTZERO);
      addBranchCase(SUB, 3'd1, 3'd3, zero, pos, NEGATIVE);
      addBranchCase(ADD, 3'd3, 3'd3, pos, pos, NEGATIVE);
      addBranchCase(ADD, 3'd2, 3'd1, neg, zero, NEGATIVE);
      prog.push_back(regInstr(HALT, 3'd0, 3'd0, 3'd0));
      runProgram("branch");
   endtask

   task automatic haltTest();
      logic [7:0] pushAddr;
      pushAddr = 8'(`STACK_TOP - 1);          // First PUSH after reset lands here
      prog.delete();
      expected.delete();
      prog.push_back(immInstr(LDI, 3'd1, 9'd5));
      prog.push_back(regInstr(PUSH, 3'd0, 3'd1, 3'd0));
      prog.push_back(regInstr(PUSH, 3'd0, 3'd1, 3'd0));
      prog.push_back(regInstr(OUT, 3'd0, 3'd1, 3'd0));
      prog.push_back(regInstr(HALT, 3'd0, 3'd0, 3'd0));
      prog.push_back(regInstr(OUT, 3'd0, 3'd1, 3'd0));   // Never reached
      expected.push_back(16'd5);
      runProgram("halt");

      prog.delete();
      expected.delete();
      prog.push_back(immInstr(LDI, 3'd1, -9'sd100));
      prog.push_back(regInstr(PUSH, 3'd0, 3'd1, 3'd0));
      prog.push_back(immInstr(LDI, 3'd2, {1'b0, pushAddr}));
      prog.push_back(regInstr(LD, 3'd3, 3'd2, 3'd0));
      prog.push_back(regInstr(OUT, 3'd0, 3'd3, 3'd0));
      prog.push_back(regInstr(POP, 3'd4, 3'd0, 3'd0));
      prog.push_back(regInstr(OUT, 3'd0, 3'd4, 3'd0));
      prog.push_back(regInstr(HALT, 3'd0, 3'd0, 3'd0));
      expected.push_back(signExtend(-9'sd100));
      expected.push_back(signExtend(-9'sd100));
      runProgram("reload");
   endtask

   initial begin
      reset     = 1'b1;
      run       = 1'b0;
      progWrite = 1'b0;
      progAddr  = 8'd0;
      progData  = 16'd0;
      aluTest();
      memoryTest();
      stackTest();
      branchTest();
      haltTest();
      $display("Errors: %0d mismatches, %0d other failures", mismatchCount, otherCount);
      if (mismatchCount == 0 && otherCount == 0) begin
         $display("SIMULATION PASSED");
      end else begin
         $display("SIMULATION FAILED");
      end
      $finish;
   end

endmodule

//--- filelist.f
+incdir+logic
+incdir+testbench
logic/cpuPkg.sv
logic/decodeStage.sv
logic/decodeRegister.sv
logic/executeStage.sv
logic/resultStage.sv
logic/cpuCore.sv
testbench/cpuCore_tb.sv

//--- runSim.sh
#!/bin/sh
# Build and run the cpuCore testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f filelist.f --top-module cpuCore_tb -o cpuSim

simOutput=$(./obj_dir/cpuSim)
echo "$simOutput"

if echo "$simOutput" | grep -q "SIMULATION PASSED"; then
   exit 0
else
   exit 1
fi
